// ==== Makefile ====
# Verilator build and run of the seq_acc testbench

TOP := tb_seq_acc

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f seq_acc.f -o V$(TOP)

# Passes only when the pass line shows up in the simulation output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// ==== hw/bitplane_sequencer.sv ====
/*
 * Bit-plane sequencer
 * Sign-magnitude split, serial plane buffers, pipeline tracker
 * and the strobes decoded from it
 */

`timescale 1ns/1ps
`include "qracc_defines.svh"
`default_nettype none

module bitplane_sequencer (
    input  wire                 clk,
    input  wire                 nrst,
    input  qracc_pkg::in_vec_t  mac_data_i,
    input  wire                 mac_valid_i,
    output logic                ready_o,
    output qracc_pkg::plane_t   plane_p_o,
    output qracc_pkg::plane_t   plane_n_o,
    output logic                mac_en_o,
    output logic                first_o,
    output logic                last_o
);
    import qracc_pkg::*;

    // One stage per plane plus the ADC register and the last add
    localparam int STAGES = `QRACC_TRITS + 2;

    mag_t [`QRACC_ROWS-1:0] mag_p;
    mag_t [`QRACC_ROWS-1:0] mag_n;
    mag_t [`QRACC_ROWS-1:0] buf_p_q;
    mag_t [`QRACC_ROWS-1:0] buf_n_q;
    logic [STAGES-1:0]      track_q;
    seq_state_t             state_q;
    seq_state_t             state_d;
    logic                   accept;

    assign accept = mac_valid_i && ready_o;

    // Sign-magnitude split
    // -16 has no positive twin and clamps to -15
    always_comb begin
        for (int r = 0; r < `QRACC_ROWS; r++) begin
            mag_p[r] = '0;
            mag_n[r] = '0;
            if (!mac_data_i[r][`QRACC_IN_BITS-1]) begin
                mag_p[r] = mac_data_i[r][`QRACC_TRITS-1:0];
            end else if (mac_data_i[r][`QRACC_TRITS-1:0] == '0) begin
                mag_n[r] = '1;
            end else begin
                mag_n[r] = mag_t'(-mac_data_i[r]);
            end
        end
    end

    // Load on acceptance, otherwise move to the next plane
    always_ff @(posedge clk) begin
        if (!nrst) begin
            buf_p_q <= '0;
            buf_n_q <= '0;
            track_q <= '0;
        end else begin
            track_q <= {track_q[STAGES-2:0], accept};
            if (accept) begin
                buf_p_q <= mag_p;
                buf_n_q <= mag_n;
            end else begin
                for (int r = 0; r < `QRACC_ROWS; r++) begin
                    buf_p_q[r] <= buf_p_q[r] >> 1;
                    buf_n_q[r] <= buf_n_q[r] >> 1;
                end
            end
        end
    end

    // BUSY while stages 0 to 2 hold an item
    always_comb begin
        state_d = IDLE;
        if (accept || track_q[0] || track_q[1]) begin
            state_d = BUSY;
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign ready_o = (state_q == IDLE);

    // Current plane is bit 0 of each buffer
    always_comb begin
        for (int r = 0; r < `QRACC_ROWS; r++) begin
            plane_p_o[r] = buf_p_q[r][0];
            plane_n_o[r] = buf_n_q[r][0];
        end
    end

    assign mac_en_o = |track_q[`QRACC_TRITS-1:0];
    assign first_o  = track_q[1];
    assign last_o   = track_q[STAGES-1];

    // Front stages must be empty when a new vector enters
    a_no_early_accept : assert property (
        @(posedge clk) disable iff (!nrst)
        accept |-> (track_q[2:0] == '0)
    );

endmodule

`default_nettype wire

// ==== hw/crossbar_mac.sv ====
/*
 * Behavioral model of the compute-in-memory array
 * Saturated signed column sums, one bit plane per cycle
 */

`timescale 1ns/1ps
`include "qracc_defines.svh"
`default_nettype none

module crossbar_mac (
    input  wire                     clk,
    input  wire                     nrst,
    input  qracc_pkg::weight_mat_t  weights_i,
    input  qracc_pkg::plane_t       plane_p_i,
    input  qracc_pkg::plane_t       plane_n_i,
    input  wire                     mac_en_i,
    output qracc_pkg::adc_vec_t     adc_o
);
    import qracc_pkg::*;

    // Enough headroom for a sum over every row
    localparam int SUM_BITS = $clog2(`QRACC_ROWS) + 2;
    localparam int ADC_MAX  = 2 ** (`QRACC_ADC_BITS - 1) - 1;
    localparam int ADC_MIN  = -(2 ** (`QRACC_ADC_BITS - 1));

    adc_vec_t adc_d;
    adc_vec_t adc_q;

    // Weighted sum of one column, clipped to the ADC range
    function automatic adc_t col_sum(
        input plane_t      p,
        input plane_t      n,
        input weight_mat_t w,
        input int          col
    );
        logic signed [SUM_BITS-1:0] s;
        s = '0;
        for (int r = 0; r < `QRACC_ROWS; r++) begin
            if (w[r][col] && p[r]) begin
                s = s + 1;
            end
            if (w[r][col] && n[r]) begin
                s = s - 1;
            end
        end
        if (s > ADC_MAX) begin
            return adc_t'(ADC_MAX);
        end
        if (s < ADC_MIN) begin
            return adc_t'(ADC_MIN);
        end
        return adc_t'(s);
    endfunction

    always_comb begin
        for (int c = 0; c < `QRACC_COLS; c++) begin
            adc_d[c] = col_sum(plane_p_i, plane_n_i, weights_i, c);
        end
    end

    // ADC sample, held while the array is idle
    always_ff @(posedge clk) begin
        if (!nrst) begin
            adc_q <= '0;
        end else if (mac_en_i) begin
            adc_q <= adc_d;
        end
    end

    assign adc_o = adc_q;

    // Sign-magnitude split never drives both lines of a row
    a_planes_exclusive : assert property (
        @(posedge clk) disable iff (!nrst)
        mac_en_i |-> ((plane_p_i & plane_n_i) == '0)
    );

endmodule

`default_nettype wire

// ==== hw/qracc_defines.svh ====
/*
 * Size parameters of the bit-serial MAC datapath
 * Array geometry, input and ADC widths, accumulator and scaling widths
 */

`ifndef QRACC_DEFINES_SVH
`define QRACC_DEFINES_SVH

`default_nettype none

// Array geometry
`define QRACC_ROWS 8
`define QRACC_COLS 4

// Two's-complement input width and number of magnitude planes
`define QRACC_IN_BITS 5
`define QRACC_TRITS 4

// Signed column sum from the array
`define QRACC_ADC_BITS 4

// Accumulator and output element width
`define QRACC_ACC_BITS 16

// Output scaling shift
`define QRACC_SHIFT_BITS 2

`default_nettype wire

`endif

// ==== hw/qracc_pkg.sv ====
/*
 * Datapath types of the MAC accelerator
 * Input, plane, ADC and accumulator vectors, weight matrix,
 * configuration struct and sequencer state enum
 */

`include "qracc_defines.svh"
`default_nettype none

package qracc_pkg;

    // One two's-complement input and the full input vector
    typedef logic [`QRACC_IN_BITS-1:0] in_elem_t;
    typedef in_elem_t [`QRACC_ROWS-1:0] in_vec_t;

    // Magnitude of one input, one bit per plane
    typedef logic [`QRACC_TRITS-1:0] mag_t;

    // One bit per array row
    typedef logic [`QRACC_ROWS-1:0] plane_t;

    // Signed column sum and one per column
    typedef logic signed [`QRACC_ADC_BITS-1:0] adc_t;
    typedef adc_t [`QRACC_COLS-1:0] adc_vec_t;

    // Accumulator word and output vector
    typedef logic signed [`QRACC_ACC_BITS-1:0] acc_t;
    typedef acc_t [`QRACC_COLS-1:0] out_vec_t;

    // Weights, indexed [row][col]
    typedef logic [`QRACC_COLS-1:0] weight_row_t;
    typedef weight_row_t [`QRACC_ROWS-1:0] weight_mat_t;

    typedef struct packed {
        logic [`QRACC_SHIFT_BITS-1:0] adc_ref_range_shifts;
    } qracc_config_t;

    // Sequencer front end occupancy
    typedef enum logic {
        IDLE,
        BUSY
    } seq_state_t;

endpackage

`default_nettype wire

// ==== hw/qracc_sram_pkg.sv ====
/*
 * Weight SRAM port types
 * Request and response structs
 */

`include "qracc_defines.svh"
`default_nettype none

package qracc_sram_pkg;

    // Row address into the weight bank
    typedef logic [$clog2(`QRACC_ROWS)-1:0] sram_addr_t;

    // Request from the host side
    typedef struct packed {
        logic                   wr_en;
        logic                   rd_en;
        sram_addr_t             addr;
        qracc_pkg::weight_row_t wdata;
    } to_sram_t;

    // Registered readback
    typedef struct packed {
        logic                   rvalid;
        qracc_pkg::weight_row_t rdata;
    } from_sram_t;

endpackage

`default_nettype wire

// ==== hw/seq_acc.sv ====
/*
 * Bit-serial MAC accelerator top
 * Weight bank, plane sequencer, array model and shift accumulator
 */

`timescale 1ns/1ps
`include "qracc_defines.svh"
`default_nettype none

module seq_acc (
    input  wire                         clk,
    input  wire                         nrst,
    input  qracc_pkg::qracc_config_t    cfg_i,

    // Input vector
    input  qracc_pkg::in_vec_t          mac_data_i,
    input  wire                         mac_valid_i,
    output logic                        ready_o,

    // Result, no back-pressure
    output logic                        valid_o,
    output qracc_pkg::out_vec_t         mac_data_o,

    // Weight port
    input  qracc_sram_pkg::to_sram_t    to_sram_i,
    output qracc_sram_pkg::from_sram_t  from_sram_o
);
    import qracc_pkg::*;

    weight_mat_t weights;
    plane_t      plane_p;
    plane_t      plane_n;
    logic        mac_en;
    logic        first;
    adc_vec_t    adc;

    weight_bank u_weight_bank (
        .clk         (clk),
        .nrst        (nrst),
        .to_sram_i   (to_sram_i),
        .from_sram_o (from_sram_o),
        .weights_o   (weights)
    );

    bitplane_sequencer u_bitplane_sequencer (
        .clk         (clk),
        .nrst        (nrst),
        .mac_data_i  (mac_data_i),
        .mac_valid_i (mac_valid_i),
        .ready_o     (ready_o),
        .plane_p_o   (plane_p),
        .plane_n_o   (plane_n),
        .mac_en_o    (mac_en),
        .first_o     (first),
        .last_o      (valid_o)
    );

    crossbar_mac u_crossbar_mac (
        .clk       (clk),
        .nrst      (nrst),
        .weights_i (weights),
        .plane_p_i (plane_p),
        .plane_n_i (plane_n),
        .mac_en_i  (mac_en),
        .adc_o     (adc)
    );

    // Result is final during the valid_o cycle
    shift_accumulator u_shift_accumulator (
        .clk        (clk),
        .nrst       (nrst),
        .adc_i      (adc),
        .first_i    (first),
        .cfg_i      (cfg_i),
        .mac_data_o (mac_data_o)
    );

endmodule

`default_nettype wire

// ==== hw/shift_accumulator.sv ====
/*
 * Shift-add accumulator
 * Rebuilds column dot products from plane sums and scales the result
 */

`timescale 1ns/1ps
`include "qracc_defines.svh"
`default_nettype none

module shift_accumulator (
    input  wire                       clk,
    input  wire                       nrst,
    input  qracc_pkg::adc_vec_t       adc_i,
    input  wire                       first_i,
    input  qracc_pkg::qracc_config_t  cfg_i,
    output qracc_pkg::out_vec_t       mac_data_o
);
    import qracc_pkg::*;

    // Each plane enters at the weight of the last one
    localparam int TOP_SHIFT = `QRACC_TRITS - 1;

    out_vec_t acc_q;
    out_vec_t adc_ext;

    // Sign extend and align each column sum
    always_comb begin
        for (int c = 0; c < `QRACC_COLS; c++) begin
            adc_ext[c] = acc_t'(signed'(adc_i[c])) <<< TOP_SHIFT;
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            acc_q <= '0;
        end else begin
            for (int c = 0; c < `QRACC_COLS; c++) begin
                if (first_i) begin
                    acc_q[c] <= adc_ext[c];
                end else begin
                    // Older planes drop one weight step
                    acc_q[c] <= ($signed(acc_q[c]) >>> 1) + adc_ext[c];
                end
            end
        end
    end

    // Output scaling
    always_comb begin
        for (int c = 0; c < `QRACC_COLS; c++) begin
            mac_data_o[c] = acc_q[c] << cfg_i.adc_ref_range_shifts;
        end
    end

endmodule

`default_nettype wire

// ==== hw/weight_bank.sv ====
/*
 * Weight storage of the array
 * Single write port, registered readback, full matrix view
 */

`timescale 1ns/1ps
`include "qracc_defines.svh"
`default_nettype none

module weight_bank (
    input  wire                       clk,
    input  wire                       nrst,
    input  qracc_sram_pkg::to_sram_t   to_sram_i,
    output qracc_sram_pkg::from_sram_t from_sram_o,
    output qracc_pkg::weight_mat_t     weights_o
);
    import qracc_pkg::*;

    weight_mat_t weights_q;
    weight_row_t rdata_q;
    logic        rvalid_q;

    // Weight rows, one written per cycle
    always_ff @(posedge clk) begin
        if (to_sram_i.wr_en) begin
            weights_q[to_sram_i.addr] <= to_sram_i.wdata;
        end
    end

    // Read data lands one cycle after rd_en
    always_ff @(posedge clk) begin
        if (to_sram_i.rd_en) begin
            rdata_q <= weights_q[to_sram_i.addr];
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= to_sram_i.rd_en;
        end
    end

    assign from_sram_o.rvalid = rvalid_q;
    assign from_sram_o.rdata  = rdata_q;

    // Whole matrix goes straight to the array
    assign weights_o = weights_q;

    // One port, one operation per cycle
    a_no_rw_collision : assert property (
        @(posedge clk) disable iff (!nrst)
        !(to_sram_i.rd_en && to_sram_i.wr_en)
    );

endmodule

`default_nettype wire

// ==== seq_acc.f ====
+incdir+hw
hw/qracc_pkg.sv
hw/qracc_sram_pkg.sv
hw/weight_bank.sv
hw/bitplane_sequencer.sv
hw/crossbar_mac.sv
hw/shift_accumulator.sv
hw/seq_acc.sv
tb/tb_seq_acc.sv

// ==== tb/tb_seq_acc.sv ====
/*
 * Testbench of the bit-serial MAC accelerator
 * Reference model, expected-result queue, stimulus tasks
 * and concurrent assertions on results, strobes and the weight port
 */

`timescale 1ns/1ps
`include "qracc_defines.svh"
`default_nettype none

module tb_seq_acc;
    import qracc_pkg::*;
    import qracc_sram_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int ROWS       = `QRACC_ROWS;
    localparam int N_SINGLE   = 16;
    localparam int N_B2B      = 12;
    localparam int N_SCALE    = 2;
    localparam int TOTAL_VECTORS = N_SINGLE + N_B2B + 2 + 4 * N_SCALE;
    // Weight loads cost a cycle per row on top of the vectors
    localparam int WEIGHT_LOADS = N_SINGLE + 5;
    localparam int WATCHDOG_CYCLES = TOTAL_VECTORS * 8 + WEIGHT_LOADS * 2 * ROWS + 100;
    localparam int RESULT_TIMEOUT = 8 * (N_B2B + 4);
    localparam int ADC_MAX = (1 << (`QRACC_ADC_BITS - 1)) - 1;
    localparam int ADC_MIN = -(1 << (`QRACC_ADC_BITS - 1));

    logic          clk;
    logic          nrst;
    qracc_config_t cfg_i;
    in_vec_t       mac_data_i;
    logic          mac_valid_i;
    logic          ready_o;
    logic          valid_o;
    out_vec_t      mac_data_o;
    to_sram_t      to_sram_i;
    from_sram_t    from_sram_o;

    weight_row_t   w_model [ROWS];
    weight_row_t   rd_expect;
    out_vec_t      exp_q [$];

    // Result capture, updated on the falling edge and checked on the rising one
    logic          chk_valid;
    logic          chk_have;
    out_vec_t      chk_got;
    out_vec_t      chk_exp;

    int            errors;
    int            test_errors_start;
    int            tests_run;
    int            tests_failed;

    seq_acc dut (
        .clk         (clk),
        .nrst        (nrst),
        .cfg_i       (cfg_i),
        .mac_data_i  (mac_data_i),
        .mac_valid_i (mac_valid_i),
        .ready_o     (ready_o),
        .valid_o     (valid_o),
        .mac_data_o  (mac_data_o),
        .to_sram_i   (to_sram_i),
        .from_sram_o (from_sram_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Clamp, split into planes, saturate each plane sum, shift-add, scale
    function automatic out_vec_t expected_result(input in_vec_t x, input int shift);
        out_vec_t res;
        int       mag [ROWS];
        int       sgn [ROWS];
        int       v;
        int       plane_sum;
        int       total;
        for (int r = 0; r < ROWS; r++) begin
            v = int'($signed(x[r]));
            if (v < -15) begin
                v = -15;
            end
            sgn[r] = (v < 0) ? -1 : 1;
            mag[r] = (v < 0) ? -v : v;
        end
        for (int c = 0; c < `QRACC_COLS; c++) begin
            total = 0;
            for (int k = 0; k < `QRACC_TRITS; k++) begin
                plane_sum = 0;
                for (int r = 0; r < ROWS; r++) begin
                    if (w_model[r][c] && ((mag[r] >> k) & 1) == 1) begin
                        plane_sum += sgn[r];
                    end
                end
                if (plane_sum > ADC_MAX) plane_sum = ADC_MAX;
                if (plane_sum < ADC_MIN) plane_sum = ADC_MIN;
                total += plane_sum * (1 << k);
            end
            res[c] = acc_t'(total * (1 << shift));
        end
        return res;
    endfunction

    function automatic in_vec_t random_vector();
        in_vec_t x;
        for (int r = 0; r < ROWS; r++) begin
            x[r] = in_elem_t'($urandom);
        end
        return x;
    endfunction

    always @(negedge clk) begin
        chk_valid = valid_o;
        chk_have  = 1'b0;
        if (valid_o) begin
            chk_got = mac_data_o;
            if (exp_q.size() > 0) begin
                chk_exp  = exp_q.pop_front();
                chk_have = 1'b1;
            end
        end
    end

    a_result_value : assert property (@(posedge clk) disable iff (!nrst)
        (chk_valid && chk_have) |-> (chk_got == chk_exp))
        else begin
            errors++;
            $display("MISMATCH mac_data_o: got %h expected %h", chk_got, chk_exp);
        end

    a_result_expected : assert property (@(posedge clk) disable iff (!nrst)
        chk_valid |-> chk_have)
        else begin
            errors++;
            $display("valid_o pulsed with no vector pending");
        end

    a_valid_timing : assert property (@(posedge clk) disable iff (!nrst)
        (mac_valid_i && ready_o) |-> ##6 valid_o)
        else begin
            errors++;
            $display("valid_o did not pulse six cycles after acceptance");
        end

    a_valid_pulse : assert property (@(posedge clk) disable iff (!nrst)
        valid_o |=> !valid_o)
        else begin
            errors++;
            $display("valid_o stayed high for more than one cycle");
        end

    a_ready_gap : assert property (@(posedge clk) disable iff (!nrst)
        (mac_valid_i && ready_o) |=> !ready_o ##1 !ready_o ##1 !ready_o ##1 ready_o)
        else begin
            errors++;
            $display("ready_o was not low for exactly three cycles after acceptance");
        end

    a_rvalid_follows : assert property (@(posedge clk) disable iff (!nrst)
        to_sram_i.rd_en |=> from_sram_o.rvalid)
        else begin
            errors++;
            $display("rvalid missing one cycle after rd_en");
        end

    a_rvalid_only : assert property (@(posedge clk) disable iff (!nrst)
        from_sram_o.rvalid |-> $past(to_sram_i.rd_en))
        else begin
            errors++;
            $display("rvalid high without rd_en in the previous cycle");
        end

    // Reads are spaced by an idle cycle, so rd_expect and rdata are stable here
    a_rdata : assert property (@(posedge clk) disable iff (!nrst)
        to_sram_i.rd_en |=> (from_sram_o.rdata == rd_expect))
        else begin
            errors++;
            $display("MISMATCH from_sram_o.rdata: got %h expected %h",
                     from_sram_o.rdata, rd_expect);
        end

    task automatic begin_test();
        test_errors_start = errors;
        tests_run++;
    endtask

    task automatic end_test(input string name);
        if (errors == test_errors_start) begin
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name,
                     errors - test_errors_start);
        end
    endtask

    task automatic write_row(input int addr, input weight_row_t data);
        to_sram_i.wr_en = 1'b1;
        to_sram_i.addr  = sram_addr_t'(addr);
        to_sram_i.wdata = data;
        w_model[addr]   = data;
        @(negedge clk);
        to_sram_i = '0;
    endtask

    task automatic read_row(input int addr);
        to_sram_i.rd_en = 1'b1;
        to_sram_i.addr  = sram_addr_t'(addr);
        rd_expect       = w_model[addr];
        @(negedge clk);
        to_sram_i = '0;
        @(negedge clk);
    endtask

    task automatic load_random_weights();
        for (int r = 0; r < ROWS; r++) begin
            write_row(r, weight_row_t'($urandom));
        end
    endtask

    // Leaves mac_valid_i high so that calls can follow back to back
    task automatic send_vector(input in_vec_t x);
        mac_valid_i = 1'b1;
        mac_data_i  = x;
        exp_q.push_back(expected_result(x, int'(cfg_i.adc_ref_range_shifts)));
        while (!ready_o) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic wait_results();
        int cycles;
        mac_valid_i = 1'b0;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < RESULT_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        a_results_drained : assert (exp_q.size() == 0)
            else begin
                errors++;
                $display("Timed out with %0d results still pending", exp_q.size());
            end
        exp_q.delete();
        // Last check runs at the next rising edge
        @(negedge clk);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        in_vec_t x;
        clk          = 1'b0;
        nrst         = 1'b0;
        cfg_i        = '0;
        mac_data_i   = '0;
        mac_valid_i  = 1'b0;
        to_sram_i    = '0;
        rd_expect    = '0;
        chk_valid    = 1'b0;
        chk_have     = 1'b0;
        chk_got      = '0;
        chk_exp      = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(25));

        repeat (2) @(negedge clk);
        nrst = 1'b1;

        begin_test();
        a_reset_state : assert (valid_o == 1'b0 && ready_o == 1'b1)
            else begin
                errors++;
                $display("After reset valid_o or ready_o has the wrong level");
            end
        end_test("reset_state");

        begin_test();
        load_random_weights();
        for (int r = 0; r < ROWS; r++) begin
            read_row(r);
        end
        end_test("weight_rw");

        begin_test();
        for (int i = 0; i < N_SINGLE; i++) begin
            load_random_weights();
            send_vector(random_vector());
            wait_results();
        end
        end_test("single_vectors");

        begin_test();
        load_random_weights();
        for (int i = 0; i < N_B2B; i++) begin
            send_vector(random_vector());
        end
        wait_results();
        end_test("back_to_back");

        begin_test();
        for (int r = 0; r < ROWS; r++) begin
            write_row(r, '1);
        end
        for (int r = 0; r < ROWS; r++) begin
            x[r] = in_elem_t'(15);
        end
        send_vector(x);
        wait_results();
        // Most negative input, clamped to -15 before the split
        for (int r = 0; r < ROWS; r++) begin
            x[r] = 5'b10000;
        end
        send_vector(x);
        wait_results();
        end_test("saturation");

        begin_test();
        load_random_weights();
        for (int s = 0; s < 4; s++) begin
            cfg_i.adc_ref_range_shifts = s[`QRACC_SHIFT_BITS-1:0];
            for (int i = 0; i < N_SCALE; i++) begin
                send_vector(random_vector());
            end
            wait_results();
        end
        end_test("output_scaling");

        repeat (2) @(negedge clk);
        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
